// ==== sources.f ====
common/fpu_pkg.sv
fpu/fpu_issue.sv
fpu/fpu_unpack.sv
fpu/fpu_compare.sv
fpu/fpu_classify.sv
fpu/fpu_transfer.sv
fpu/fpu_result.sv
fpu/fpu.sv
bench/fpu_asserts.sv
bench/fpu_tb.sv

// ==== Makefile ====
# Verilator build and regression run for the FP unit

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/fpu_tb.sv ====
// fpu_tb
// Directed testbench for the single-cycle FP unit covering sign injection,
// moves, compares, min/max, fclass, back-to-back issue and reset behaviour.

`timescale 1ns/100ps

module fpu_tb;

	import fpu_pkg::*;

	localparam int tag_w = 5;

	logic             clk;
	logic             arst_n;
	logic             enable;
	fp_req_t          req;
	logic [tag_w-1:0] rd;
	logic             res_valid;
	logic [tag_w-1:0] res_rd;
	fp_wb_t           res;
	int               cycle;
	int               errors;
	int               tests;
	logic [31:0]      rng;
	logic [63:0]      spec_d[8];
	logic [63:0]      spec_s[8];

	fpu #(.tag_w(tag_w)) fpu_i (
		.clk(clk), .arst_n(arst_n), .enable(enable), .req(req), .rd(rd),
		.res_valid(res_valid), .res_rd(res_rd), .res(res)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = xorshift();
		lo = xorshift();
		return {hi, lo};
	endfunction

	// reference model from the ISA rules
	function automatic logic is_nan_ref(logic [63:0] v, fp_fmt_e f);
		if (f == fmt_d)
			return (v[62:52] == 11'h7ff) && (v[51:0] != 0);
		if (v[63:32] != 32'hffff_ffff)
			return 1'b1;  // unboxed single
		return (v[30:23] == 8'hff) && (v[22:0] != 0);
	endfunction

	function automatic logic is_zero_ref(logic [63:0] v, fp_fmt_e f);
		return (f == fmt_d) ? (v[62:0] == 0) : (v[30:0] == 0);
	endfunction

	// unsigned key that follows the signed order with -0 below +0
	function automatic logic [63:0] order_key(logic [63:0] v, fp_fmt_e f);
		if (f == fmt_s)
			return v[31] ? {32'h0, ~v[31:0]} : {32'h0, v[31:0] | 32'h8000_0000};
		return v[63] ? ~v : (v | 64'h8000_0000_0000_0000);
	endfunction

	function automatic fp_wb_t expected_wb(fp_req_t r);
		fp_wb_t      w;
		logic        na;
		logic        nb;
		logic        lt;
		logic        eq;
		logic        sg;
		logic [63:0] ka;
		logic [63:0] kb;
		na = is_nan_ref(r.a, r.fmt);
		nb = is_nan_ref(r.b, r.fmt);
		ka = order_key(r.a, r.fmt);
		kb = order_key(r.b, r.fmt);
		lt = ka < kb;
		eq = ka == kb;
		if (is_zero_ref(r.a, r.fmt) && is_zero_ref(r.b, r.fmt)) begin
			lt = 1'b0;
			eq = 1'b1;
		end
		w = '0;
		w.to_fp = r.op inside {op_fsgnj, op_fsgnjn, op_fsgnjx, op_fmin, op_fmax, op_fmv_f};
		sg = (r.fmt == fmt_d) ? r.b[63] : r.b[31];
		case (r.op)
		op_fle: w.value[0] = !na && !nb && (lt || eq);
		op_flt: w.value[0] = !na && !nb && lt;
		op_feq: w.value[0] = !na && !nb && eq;
		op_fmin, op_fmax:
			if (na && nb)
				w.value = (r.fmt == fmt_d) ? 64'h7ff8_0000_0000_0000 : 64'hffff_ffff_7fc0_0000;
			else if (na)
				w.value = r.b;
			else if (nb)
				w.value = r.a;
			else
				w.value = ((ka < kb) == (r.op == op_fmin)) ? r.a : r.b;
		op_fsgnj, op_fsgnjn, op_fsgnjx: begin
			if (r.op == op_fsgnjn)
				sg = !sg;
			else if (r.op == op_fsgnjx)
				sg = sg ^ ((r.fmt == fmt_d) ? r.a[63] : r.a[31]);
			w.value = (r.fmt == fmt_d) ? {sg, r.a[62:0]} : {32'hffff_ffff, sg, r.a[30:0]};
		end
		op_fmv_x: w.value = (r.fmt == fmt_d) ? r.a : {{32{r.a[31]}}, r.a[31:0]};
		op_fmv_f: w.value = (r.fmt == fmt_d) ? r.x : {32'hffff_ffff, r.x[31:0]};
		default:  w.value = '0;
		endcase
		return w;
	endfunction

	task automatic check_wb(input fp_wb_t got, input fp_wb_t exp);
		if (got.value !== exp.value) begin
			$display("Mismatch res.value: got %h expected %h", got.value, exp.value);
			errors++;
		end
		if (got.to_fp !== exp.to_fp) begin
			$display("Mismatch res.to_fp: got %h expected %h", got.to_fp, exp.to_fp);
			errors++;
		end
	endtask

	task automatic check_rd(input logic [tag_w-1:0] got, input logic [tag_w-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch res_rd: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	function automatic fp_req_t make_req(fp_op_e op, fp_fmt_e f, logic [63:0] a,
			logic [63:0] b, logic [63:0] x);
		fp_req_t r;
		r.op = op;
		r.fmt = f;
		r.a = a;
		r.b = b;
		r.x = x;
		return r;
	endfunction

	// issue one request and wait for its writeback two clocks after the enable edge
	task automatic issue_and_check(input fp_req_t r, input logic [tag_w-1:0] t,
			input fp_wb_t exp);
		int c0;
		int n;
		@(posedge clk);
		c0 = cycle;
		enable <= 1'b1;
		req    <= r;
		rd     <= t;
		@(posedge clk);
		enable <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!res_valid && n < 8);
		if (!res_valid) begin
			$display("no writeback for tag %0d within 8 cycles", t);
			errors++;
		end else begin
			check_wb(res, exp);
			check_rd(res_rd, t);
			if (cycle != c0 + 3) begin
				$display("writeback for tag %0d arrived at the wrong cycle", t);
				errors++;
			end
		end
	endtask

	task automatic report(input string name, input int e0);
		tests++;
		$display("test %s done, %0d errors", name, errors - e0);
	endtask

	task automatic idle_after_reset();
		int e0;
		e0 = errors;
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if (res_valid !== 1'b0) begin
				$display("res_valid high after reset without any enable");
				errors++;
			end
		end
		check_rd(res_rd, '0);
		check_wb(res, '0);
		report("reset", e0);
	endtask

	task automatic sign_and_moves();
		fp_op_e  ops[5] = '{op_fsgnj, op_fsgnjn, op_fsgnjx, op_fmv_x, op_fmv_f};
		fp_req_t r;
		int      e0;
		e0 = errors;
		for (int i = 0; i < 8; i++)
			foreach (ops[k]) begin
				r = make_req(ops[k], fp_fmt_e'(i % 2), rand64(), rand64(), rand64());
				issue_and_check(r, 5'(i + k), expected_wb(r));
			end
		report("sgnj_moves", e0);
	endtask

	task automatic compare_ops();
		fp_op_e  ops[3] = '{op_fle, op_flt, op_feq};
		fp_req_t r;
		int      e0;
		e0 = errors;
		foreach (ops[k])
			for (int i = 0; i < 8; i++)
				for (int j = 0; j < 8; j++) begin
					r = make_req(ops[k], fmt_d, spec_d[i], spec_d[j], '0);
					issue_and_check(r, 5'(j), expected_wb(r));
					r = make_req(ops[k], fmt_s, spec_s[i], spec_s[j], '0);
					issue_and_check(r, 5'(i), expected_wb(r));
				end
		for (int i = 0; i < 20; i++) begin
			r = make_req(ops[i % 3], fmt_d, rand64(), rand64(), '0);
			issue_and_check(r, 5'(i), expected_wb(r));
		end
		report("compare", e0);
	endtask

	task automatic min_max_ops();
		fp_req_t r;
		int      e0;
		e0 = errors;
		for (int i = 0; i < 8; i++)
			for (int j = 0; j < 8; j++) begin
				r = make_req((i + j) % 2 ? op_fmax : op_fmin, fmt_d, spec_d[i], spec_d[j], '0);
				issue_and_check(r, 5'(i), expected_wb(r));
				r = make_req((i + j) % 2 ? op_fmin : op_fmax, fmt_s, spec_s[i], spec_s[j], '0);
				issue_and_check(r, 5'(j), expected_wb(r));
			end
		// two NaNs with one signalling, then the zero ordering
		r = make_req(op_fmin, fmt_d, 64'h7ff0_0000_0000_0001, 64'hfff8_0000_0000_0abc, '0);
		issue_and_check(r, 5'd1, '{value: 64'h7ff8_0000_0000_0000, to_fp: 1'b1});
		r = make_req(op_fmax, fmt_s, 64'hffff_ffff_7f80_0001, 64'h1234_5678_0000_0000, '0);
		issue_and_check(r, 5'd2, '{value: 64'hffff_ffff_7fc0_0000, to_fp: 1'b1});
		r = make_req(op_fmin, fmt_d, 64'h0, 64'h8000_0000_0000_0000, '0);
		issue_and_check(r, 5'd3, '{value: 64'h8000_0000_0000_0000, to_fp: 1'b1});
		report("minmax", e0);
	endtask

	task automatic classify_values();
		logic [63:0] vd[10] = '{64'hfff0_0000_0000_0000, 64'hbff0_0000_0000_0000,
			64'h8000_0000_0000_0001, 64'h8000_0000_0000_0000, 64'h0, 64'h1,
			64'h3ff0_0000_0000_0000, 64'h7ff0_0000_0000_0000,
			64'h7ff0_0000_0000_0001, 64'h7ff8_0000_0000_0000};
		logic [31:0] vs[10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
			32'h0, 32'h1, 32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001, 32'h7fc0_0000};
		fp_wb_t      w;
		int          e0;
		e0 = errors;
		for (int i = 0; i < 10; i++) begin
			w = '{value: 64'(1) << i, to_fp: 1'b0};  // index i is the class bit
			issue_and_check(make_req(op_fclass, fmt_d, vd[i], '0, '0), 5'(i), w);
			issue_and_check(make_req(op_fclass, fmt_s, {32'hffff_ffff, vs[i]}, '0, '0),
				5'(i), w);
		end
		w = '{value: 64'h200, to_fp: 1'b0};
		issue_and_check(make_req(op_fclass, fmt_s, 64'h0000_0000_3f80_0000, '0, '0), 5'd11, w);
		report("fclass", e0);
	endtask

	task automatic back_to_back_issue();
		fp_req_t          r[4];
		int               c_issue[4];
		int               c_seen[4];
		fp_wb_t           w_seen[4];
		logic [tag_w-1:0] t_seen[4];
		int               n;
		int               e0;
		e0 = errors;
		r[0] = make_req(op_fsgnjn, fmt_d, rand64(), rand64(), '0);
		r[1] = make_req(op_flt, fmt_d, spec_d[6], spec_d[4], '0);
		r[2] = make_req(op_fmv_f, fmt_s, '0, '0, rand64());
		r[3] = make_req(op_fmax, fmt_s, spec_s[7], spec_s[1], '0);
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					@(posedge clk);
					c_issue[i] = cycle;
					enable <= 1'b1;
					req    <= r[i];
					rd     <= 5'(20 + i);
				end
				@(posedge clk);
				enable <= 1'b0;
			end
			for (int k = 0; k < 4; k++) begin
				n = 0;
				do begin
					@(negedge clk);
					n++;
				end while (!res_valid && n < 12);
				c_seen[k] = res_valid ? cycle : -1;
				w_seen[k] = res;
				t_seen[k] = res_rd;
			end
		join
		for (int k = 0; k < 4; k++) begin
			if (c_seen[k] != c_issue[k] + 3) begin
				$display("writeback %0d of the burst missing or at the wrong cycle", k);
				errors++;
			end
			check_wb(w_seen[k], expected_wb(r[k]));
			check_rd(t_seen[k], 5'(20 + k));
		end
		report("back_to_back", e0);
	endtask

	initial begin
		spec_d = '{64'h0, 64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0000,
			64'hfff0_0000_0000_0000, 64'h7ff8_0000_0000_0000, 64'h3ff0_0000_0000_0000,
			64'hbff0_0000_0000_0000, 64'h7ff0_0000_0000_0001};
		spec_s = '{64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000, 64'hffff_ffff_7f80_0000,
			64'hffff_ffff_ff80_0000, 64'hffff_ffff_7fc0_0000, 64'hffff_ffff_3f80_0000,
			64'hffff_ffff_bf80_0000, 64'h0000_0000_3f80_0000};
		rng    = 32'h907f70e9;
		cycle  = 0;
		errors = 0;
		tests  = 0;
		arst_n = 1'b0;
		enable = 1'b0;
		req    = '0;
		rd     = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		idle_after_reset();
		sign_and_moves();
		compare_ops();
		min_max_ops();
		classify_values();
		back_to_back_issue();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== bench/fpu_asserts.sv ====
// fpu_asserts
// Writeback checks on the FP unit: valid timing, reset and the
// one-hot fclass mask. Bound into every fpu instance.

`timescale 1ns/100ps

module fpu_asserts (
	input logic            clk,
	input logic            arst_n,
	input logic            iss_valid,
	input logic            res_valid,
	input fpu_pkg::fp_op_e op,
	input logic [9:0]      mask
);

	import fpu_pkg::*;

	// one clock from issue to writeback
	valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |-> res_valid == $past(iss_valid))
		else $error("res_valid does not follow iss_valid");

	quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !res_valid)
		else $error("res_valid high during reset");

	class_one_hot: assert property (@(posedge clk) disable iff (!arst_n)
		(iss_valid && op == op_fclass) |-> $onehot(mask))
		else $error("fclass mask not one-hot");

endmodule

bind fpu fpu_asserts asserts_i (
	.clk(clk), .arst_n(arst_n), .iss_valid(iss_valid), .res_valid(res_valid),
	.op(iss_req.op), .mask(mask)
);

// ==== fpu/fpu.sv ====
// fpu
// Single-cycle half of the FP execution unit. A request taken with
// enable is written back with its tag two clocks later.

`timescale 1ns/100ps

module fpu #(
	parameter int tag_w = 5
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             enable,
	input  fpu_pkg::fp_req_t req,
	input  logic [tag_w-1:0] rd,
	output logic             res_valid,
	output logic [tag_w-1:0] res_rd,
	output fpu_pkg::fp_wb_t  res
);

	import fpu_pkg::*;

	logic             iss_valid;
	fp_req_t          iss_req;
	logic [tag_w-1:0] iss_rd;
	fp_fields_t       fields_a;
	fp_fields_t       fields_b;
	logic             cmp_bit;
	logic [xlen-1:0]  minmax;
	logic [9:0]       mask;
	logic [xlen-1:0]  xfer;

	fpu_issue #(.tag_w(tag_w)) u_issue (
		.clk(clk), .arst_n(arst_n), .enable(enable), .req(req), .rd(rd),
		.iss_valid(iss_valid), .iss_req(iss_req), .iss_rd(iss_rd)
	);

	fpu_unpack u_unpack_a (.val(iss_req.a), .fmt(iss_req.fmt), .fields(fields_a));
	fpu_unpack u_unpack_b (.val(iss_req.b), .fmt(iss_req.fmt), .fields(fields_b));

	fpu_compare u_compare (
		.op(iss_req.op), .fmt(iss_req.fmt), .a(iss_req.a), .b(iss_req.b),
		.fa(fields_a), .fb(fields_b), .cmp_bit(cmp_bit), .minmax(minmax)
	);

	fpu_classify u_classify (.fmt(iss_req.fmt), .f(fields_a), .mask(mask));

	fpu_transfer u_transfer (
		.op(iss_req.op), .fmt(iss_req.fmt), .a(iss_req.a), .b(iss_req.b),
		.x(iss_req.x), .value(xfer)
	);

	fpu_result #(.tag_w(tag_w)) u_result (
		.clk(clk), .arst_n(arst_n), .iss_valid(iss_valid), .iss_rd(iss_rd),
		.op(iss_req.op), .cmp_bit(cmp_bit), .minmax(minmax), .mask(mask), .xfer(xfer),
		.res_valid(res_valid), .res_rd(res_rd), .res(res)
	);

endmodule

// ==== fpu/fpu_result.sv ====
// fpu_result
// Picks the result for the issued opcode and registers the writeback
// with its valid bit and destination tag.

`timescale 1ns/100ps

module fpu_result #(
	parameter int tag_w = 5
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     iss_valid,
	input  logic [tag_w-1:0]         iss_rd,
	input  fpu_pkg::fp_op_e          op,
	input  logic                     cmp_bit,
	input  logic [fpu_pkg::xlen-1:0] minmax,
	input  logic [9:0]               mask,
	input  logic [fpu_pkg::xlen-1:0] xfer,
	output logic                     res_valid,
	output logic [tag_w-1:0]         res_rd,
	output fpu_pkg::fp_wb_t          res
);

	import fpu_pkg::*;

	fp_wb_t wb;

	always_comb begin
		case (op)
		op_fle, op_flt, op_feq: wb = '{value: {{(xlen-1){1'b0}}, cmp_bit}, to_fp: 1'b0};
		op_fmin, op_fmax:       wb = '{value: minmax, to_fp: 1'b1};
		op_fclass:              wb = '{value: {{(xlen-10){1'b0}}, mask}, to_fp: 1'b0};
		op_fsgnj, op_fsgnjn,
		op_fsgnjx, op_fmv_f:    wb = '{value: xfer, to_fp: 1'b1};
		op_fmv_x:               wb = '{value: xfer, to_fp: 1'b0};
		default:                wb = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
			res_rd    <= '0;
			res       <= '0;
		end else begin
			res_valid <= iss_valid;
			if (iss_valid) begin  // hold last writeback when idle
				res_rd <= iss_rd;
				res    <= wb;
			end
		end
	end

endmodule

// ==== fpu/fpu_transfer.sv ====
// fpu_transfer
// Sign injection and the moves between the fp and integer register
// files. Single results bound for the fp side are NaN-boxed.

`timescale 1ns/100ps

module fpu_transfer (
	input  fpu_pkg::fp_op_e          op,
	input  fpu_pkg::fp_fmt_e         fmt,
	input  logic [fpu_pkg::xlen-1:0] a,
	input  logic [fpu_pkg::xlen-1:0] b,
	input  logic [fpu_pkg::xlen-1:0] x,
	output logic [fpu_pkg::xlen-1:0] value
);

	import fpu_pkg::*;

	logic sa;
	logic sb;
	logic new_sign;

	assign sa = (fmt == fmt_d) ? a[63] : a[31];
	assign sb = (fmt == fmt_d) ? b[63] : b[31];

	always_comb begin
		case (op)
		op_fsgnjn: new_sign = !sb;
		op_fsgnjx: new_sign = sa ^ sb;
		default:   new_sign = sb;  // fsgnj
		endcase
	end

	always_comb begin
		case (op)
		op_fsgnj, op_fsgnjn, op_fsgnjx:
			if (fmt == fmt_d)
				value = {new_sign, a[62:0]};
			else
				value = {32'hffff_ffff, new_sign, a[30:0]};
		op_fmv_x:
			value = (fmt == fmt_d) ? a : {{32{a[31]}}, a[31:0]};  // sign-extend single
		op_fmv_f:
			value = (fmt == fmt_d) ? x : {32'hffff_ffff, x[31:0]};
		default:
			value = '0;
		endcase
	end

endmodule

// ==== fpu/fpu_classify.sv ====
// fpu_classify
// Builds the one-hot fclass mask from the unpacked operand.

`timescale 1ns/100ps

module fpu_classify (
	input  fpu_pkg::fp_fmt_e    fmt,
	input  fpu_pkg::fp_fields_t f,
	output logic [9:0]          mask
);

	import fpu_pkg::*;

	logic quiet;

	// an unboxed single arrives with its raw payload, so go by is_snan there
	assign quiet = (fmt == fmt_s) ? !f.is_snan : f.man[51];

	always_comb begin
		mask[0] =  f.sign && f.is_inf;
		mask[1] =  f.sign && f.is_norm;
		mask[2] =  f.sign && f.is_sub;
		mask[3] =  f.sign && f.is_zero;
		mask[4] = !f.sign && f.is_zero;
		mask[5] = !f.sign && f.is_sub;
		mask[6] = !f.sign && f.is_norm;
		mask[7] = !f.sign && f.is_inf;
		mask[8] = f.is_nan && !quiet;  // signalling
		mask[9] = f.is_nan && quiet;
	end

endmodule

// ==== fpu/fpu_compare.sv ====
// fpu_compare
// Ordering logic for fle, flt, feq, fmin and fmax. Comparisons see
// both zeros as equal; fmin and fmax place -0 below +0.

`timescale 1ns/100ps

module fpu_compare (
	input  fpu_pkg::fp_op_e          op,
	input  fpu_pkg::fp_fmt_e         fmt,
	input  logic [fpu_pkg::xlen-1:0] a,
	input  logic [fpu_pkg::xlen-1:0] b,
	input  fpu_pkg::fp_fields_t      fa,
	input  fpu_pkg::fp_fields_t      fb,
	output logic                     cmp_bit,
	output logic [fpu_pkg::xlen-1:0] minmax
);

	import fpu_pkg::*;

	logic mag_lt;
	logic mag_eq;
	logic both_zero;
	logic any_nan;
	logic lt_ord;
	logic lt;
	logic eq;

	// exponent and mantissa together order the magnitude, inf included
	assign mag_lt    = {fa.exp, fa.man} < {fb.exp, fb.man};
	assign mag_eq    = {fa.exp, fa.man} == {fb.exp, fb.man};
	assign both_zero = fa.is_zero && fb.is_zero;
	assign any_nan   = fa.is_nan || fb.is_nan;

	// signed order, -0 below +0
	always_comb begin
		if (fa.sign != fb.sign)
			lt_ord = fa.sign;
		else if (fa.sign)
			lt_ord = !mag_lt && !mag_eq;  // both negative, larger magnitude is less
		else
			lt_ord = mag_lt;
	end

	assign lt = lt_ord && !both_zero;
	assign eq = both_zero || ((fa.sign == fb.sign) && mag_eq);

	always_comb begin
		case (op)
		op_fle:  cmp_bit = !any_nan && (lt || eq);
		op_flt:  cmp_bit = !any_nan && lt;
		op_feq:  cmp_bit = !any_nan && eq;
		default: cmp_bit = 1'b0;
		endcase
	end

	always_comb begin
		if (fa.is_nan && fb.is_nan)
			minmax = (fmt == fmt_d) ? canon_nan_d : canon_nan_s;
		else if (fa.is_nan)
			minmax = b;
		else if (fb.is_nan)
			minmax = a;
		else
			minmax = (lt_ord ^ (op == op_fmax)) ? a : b;
	end

endmodule

// ==== fpu/fpu_unpack.sv ====
// fpu_unpack
// Splits one operand into sign, exponent and mantissa in the double
// layout and derives the special-case flags. Single operands that are
// not NaN-boxed are reported as quiet NaN.

`timescale 1ns/100ps

module fpu_unpack (
	input  logic [fpu_pkg::xlen-1:0] val,
	input  fpu_pkg::fp_fmt_e         fmt,
	output fpu_pkg::fp_fields_t      fields
);

	import fpu_pkg::*;

	logic       unboxed;
	logic [7:0] exp_s;
	logic       exp_max;
	logic       exp_min;
	logic       man_nz;

	assign unboxed = (fmt == fmt_s) && (val[63:32] != 32'hffff_ffff);
	assign exp_s   = val[30:23];

	always_comb begin
		if (fmt == fmt_d) begin
			fields.sign = val[63];
			fields.exp  = val[62:52];
			fields.man  = val[51:0];
		end else begin
			fields.sign = val[31];
			if (exp_s == 8'h00)
				fields.exp = 11'h000;  // zero and subnormal
			else if (exp_s == 8'hff)
				fields.exp = 11'h7ff;  // inf and NaN
			else
				fields.exp = {3'b000, exp_s} + 11'd896;  // rebias 127 -> 1023
			fields.man = {val[22:0], 29'b0};
		end
	end

	assign exp_max = &fields.exp;
	assign exp_min = (fields.exp == 11'h000);
	assign man_nz  = |fields.man;

	always_comb begin
		fields.is_nan  = unboxed || (exp_max && man_nz);
		fields.is_snan = !unboxed && exp_max && man_nz && !fields.man[51];
		fields.is_inf  = !unboxed && exp_max && !man_nz;
		fields.is_zero = !unboxed && exp_min && !man_nz;
		fields.is_sub  = !unboxed && exp_min && man_nz;
		fields.is_norm = !unboxed && !exp_min && !exp_max;
	end

endmodule

// ==== fpu/fpu_issue.sv ====
// fpu_issue
// Issue register of the FP unit. Captures the request and its
// destination tag on enable and raises iss_valid for one cycle.

`timescale 1ns/100ps

module fpu_issue #(
	parameter int tag_w = 5
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               enable,
	input  fpu_pkg::fp_req_t   req,
	input  logic [tag_w-1:0]   rd,
	output logic               iss_valid,
	output fpu_pkg::fp_req_t   iss_req,
	output logic [tag_w-1:0]   iss_rd
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iss_valid <= 1'b0;
		end else begin
			iss_valid <= enable;  // one pulse per accepted request
		end
	end

	// operands stay put while idle, so downstream logic sees no toggling
	always_ff @(posedge clk) begin
		if (enable) begin
			iss_req <= req;
			iss_rd  <= rd;
		end
	end

endmodule

// ==== common/fpu_pkg.sv ====
// fpu_pkg
// Shared definitions for the single-cycle FP unit: register width,
// formats, opcodes, request and writeback structs, canonical NaNs.

package fpu_pkg;

	localparam int xlen = 64;

	// operand format, single is NaN-boxed in a 64-bit register
	typedef enum logic {
		fmt_s = 1'b0,
		fmt_d = 1'b1
	} fp_fmt_e;

	typedef enum logic [3:0] {
		op_fsgnj  = 4'd0,
		op_fsgnjn = 4'd1,
		op_fsgnjx = 4'd2,
		op_fmin   = 4'd3,
		op_fmax   = 4'd4,
		op_fle    = 4'd5,
		op_flt    = 4'd6,
		op_feq    = 4'd7,
		op_fclass = 4'd8,
		op_fmv_x  = 4'd9,  // fp reg to int reg
		op_fmv_f  = 4'd10  // int reg to fp reg
	} fp_op_e;

	// one request as issued to the unit
	typedef struct packed {
		fp_op_e          op;
		fp_fmt_e         fmt;
		logic [xlen-1:0] a;  // fp source 1
		logic [xlen-1:0] b;  // fp source 2
		logic [xlen-1:0] x;  // int source
	} fp_req_t;

	// unpacked operand, always in the double layout
	typedef struct packed {
		logic        sign;
		logic [10:0] exp;
		logic [51:0] man;
		logic        is_nan;
		logic        is_snan;
		logic        is_inf;
		logic        is_zero;
		logic        is_sub;
		logic        is_norm;
	} fp_fields_t;

	typedef struct packed {
		logic [xlen-1:0] value;
		logic            to_fp;  // write the fp register file
	} fp_wb_t;

	// standard quiet NaN, single one boxed
	localparam logic [xlen-1:0] canon_nan_d = 64'h7ff8_0000_0000_0000;
	localparam logic [xlen-1:0] canon_nan_s = 64'hffff_ffff_7fc0_0000;

endpackage
